// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := pixel_generator_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides, not the exit status of the binary
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+hdl
hdl/pixgen_pkg.sv
hdl/axil_regfile.sv
hdl/tile_raster.sv
hdl/gradient_shader.sv
hdl/pixel_packer.sv
hdl/pixel_generator.sv
tb/pixel_generator_chk.sv
tb/pixel_generator_tb.sv

// File: hdl/axil_regfile.sv
`timescale 1ns/1ns
`include "pixgen_settings.svh"

module axil_regfile (
    input  logic                            out_stream_aclk,
    input  logic                            periph_resetn,

    input  logic [`PIXGEN_AXIL_ADDR_W-1:0]  s_axi_lite_awaddr,
    input  logic                            s_axi_lite_awvalid,
    output logic                            s_axi_lite_awready,

    input  logic [`PIXGEN_DATA_W-1:0]       s_axi_lite_wdata,
    input  logic                            s_axi_lite_wvalid,
    output logic                            s_axi_lite_wready,

    output logic                            s_axi_lite_bvalid,
    output pixgen_pkg::axil_resp_e          s_axi_lite_bresp,
    input  logic                            s_axi_lite_bready,

    input  logic [`PIXGEN_AXIL_ADDR_W-1:0]  s_axi_lite_araddr,
    input  logic                            s_axi_lite_arvalid,
    output logic                            s_axi_lite_arready,

    output logic                            s_axi_lite_rvalid,
    output logic [`PIXGEN_DATA_W-1:0]       s_axi_lite_rdata,
    output pixgen_pkg::axil_resp_e          s_axi_lite_rresp,
    input  logic                            s_axi_lite_rready,

    output pixgen_pkg::pixgen_ctrl_t        ctrl
);

    import pixgen_pkg::*;

    // word index taken from addr[4:2]
    localparam int idx_w = $clog2(`PIXGEN_REG_COUNT);

    logic [`PIXGEN_DATA_W-1:0] regs [`PIXGEN_REG_COUNT];
    logic [idx_w-1:0]          wr_idx;
    logic [idx_w-1:0]          rd_idx;
    logic [`PIXGEN_DATA_W-1:0] wr_data;
    axil_wr_state_e            wr_state;
    axil_rd_state_e            rd_state;
    logic                      aw_fire;
    logic                      w_fire;
    logic                      ar_fire;

    assign aw_fire = s_axi_lite_awvalid && s_axi_lite_awready;
    assign w_fire  = s_axi_lite_wvalid && s_axi_lite_wready;
    assign ar_fire = s_axi_lite_arvalid && s_axi_lite_arready;

    // write FSM, address and data in any order
    always_ff @(posedge out_stream_aclk) begin
        if (!periph_resetn) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: begin
                    // both together skip straight to the write
                    case ({aw_fire, w_fire})
                        2'b11:   wr_state <= wr_write;
                        2'b10:   wr_state <= wr_wait_data;
                        2'b01:   wr_state <= wr_wait_addr;
                        default: wr_state <= wr_idle;
                    endcase
                end
                wr_wait_data: begin
                    if (w_fire) begin
                        wr_state <= wr_write;
                    end
                end
                wr_wait_addr: begin
                    if (aw_fire) begin
                        wr_state <= wr_write;
                    end
                end
                wr_write: begin
                    wr_state <= wr_resp;
                end
                wr_resp: begin
                    // response held until host takes it
                    if (s_axi_lite_bready) begin
                        wr_state <= wr_idle;
                    end
                end
                default: begin
                    wr_state <= wr_idle;
                end
            endcase
        end
    end

    // capture whichever half arrives
    always_ff @(posedge out_stream_aclk) begin
        if (aw_fire) begin
            wr_idx <= s_axi_lite_awaddr[2 +: idx_w];
        end
        if (w_fire) begin
            wr_data <= s_axi_lite_wdata;
        end
    end

    // register array, cleared on reset
    always_ff @(posedge out_stream_aclk) begin
        if (!periph_resetn) begin
            regs <= '{default: '0};
        end else if (wr_state == wr_write) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign s_axi_lite_awready = (wr_state == wr_idle) || (wr_state == wr_wait_addr);
    assign s_axi_lite_wready  = (wr_state == wr_idle) || (wr_state == wr_wait_data);
    assign s_axi_lite_bvalid  = (wr_state == wr_resp);
    assign s_axi_lite_bresp   = axil_okay;

    // read FSM, idle -> fetch -> present
    always_ff @(posedge out_stream_aclk) begin
        if (!periph_resetn) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (ar_fire) begin
                        rd_state <= rd_fetch;
                    end
                end
                rd_fetch: begin
                    rd_state <= rd_present;
                end
                rd_present: begin
                    if (s_axi_lite_rready) begin
                        rd_state <= rd_idle;
                    end
                end
                default: begin
                    rd_state <= rd_idle;
                end
            endcase
        end
    end

    // data latched once in fetch so it stays put while presented
    always_ff @(posedge out_stream_aclk) begin
        if (ar_fire) begin
            rd_idx <= s_axi_lite_araddr[2 +: idx_w];
        end
        if (rd_state == rd_fetch) begin
            s_axi_lite_rdata <= regs[rd_idx];
        end
    end

    assign s_axi_lite_arready = (rd_state == rd_idle);
    assign s_axi_lite_rvalid  = (rd_state == rd_present);
    assign s_axi_lite_rresp   = axil_okay;

    // run bit lives in reg 0 bit 0
    assign ctrl.run = regs[0][0];

endmodule

// File: hdl/gradient_shader.sv
`timescale 1ns/1ns
`include "pixgen_settings.svh"

module gradient_shader (
    input  logic                     out_stream_aclk,
    input  logic                     periph_resetn,
    input  pixgen_pkg::raster_pix_t  pos,
    input  logic                     pos_valid,
    input  logic                     advance,
    output pixgen_pkg::gray_pix_t    pix,
    output logic                     pix_valid
);

    // fp16 per row, white at row 0 down to black at last row
    // steps of 0x24 in the low bits, last row is exact zero
    localparam logic [15:0] grad_table [`PIXGEN_TILE_H] = '{
        16'h3c00, 16'h3bdc, 16'h3bb8, 16'h3b94, 16'h3b70, 16'h3b4c,
        16'h3b28, 16'h3b04, 16'h3ae0, 16'h3abc, 16'h3a98, 16'h3a74,
        16'h3a50, 16'h3a2c, 16'h3a08, 16'h39e4, 16'h39c0, 16'h399c,
        16'h3978, 16'h3954, 16'h3930, 16'h390c, 16'h38e8, 16'h0000
    };

    logic [7:0] gray_next;

    // value * 255, truncated; hidden bit restored, bias 15 and 10 fraction bits
    function automatic logic [7:0] fp16_to_gray(input logic [15:0] h);
        logic [4:0]  expo;
        logic [18:0] prod;
        logic [18:0] shifted;
        expo    = h[14:10];
        prod    = {8'd0, 1'b1, h[9:0]} * 19'd255;
        shifted = '0;
        if (h[15] || (expo == 5'd0)) begin
            // negatives, zero and subnormals all land below one gray step
            fp16_to_gray = 8'd0;
        end else if (expo >= 5'd15) begin
            // 1.0 and above saturate
            fp16_to_gray = 8'hff;
        end else begin
            shifted      = prod >> (5'd25 - expo);
            fp16_to_gray = shifted[7:0];
        end
    endfunction

    assign gray_next = fp16_to_gray(grad_table[pos.y]);

    // pipeline register, moves only on advance
    always_ff @(posedge out_stream_aclk) begin
        if (advance) begin
            pix.gray <= gray_next;
            pix.sof  <= pos.sof;
            pix.eol  <= pos.eol;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!periph_resetn) begin
            pix_valid <= 1'b0;
        end else if (advance) begin
            pix_valid <= pos_valid;
        end
    end

endmodule

// File: hdl/pixel_generator.sv
`timescale 1ns/1ns
`include "pixgen_settings.svh"

module pixel_generator (
    input  logic                            out_stream_aclk,
    input  logic                            periph_resetn,

    // stream out
    output logic [`PIXGEN_DATA_W-1:0]       out_stream_tdata,
    output logic [`PIXGEN_DATA_W/8-1:0]     out_stream_tkeep,
    output logic                            out_stream_tlast,
    input  logic                            out_stream_tready,
    output logic                            out_stream_tvalid,
    output logic [0:0]                      out_stream_tuser,

    // register slave
    input  logic [`PIXGEN_AXIL_ADDR_W-1:0]  s_axi_lite_araddr,
    output logic                            s_axi_lite_arready,
    input  logic                            s_axi_lite_arvalid,
    input  logic [`PIXGEN_AXIL_ADDR_W-1:0]  s_axi_lite_awaddr,
    output logic                            s_axi_lite_awready,
    input  logic                            s_axi_lite_awvalid,
    input  logic                            s_axi_lite_bready,
    output logic [1:0]                      s_axi_lite_bresp,
    output logic                            s_axi_lite_bvalid,
    output logic [`PIXGEN_DATA_W-1:0]       s_axi_lite_rdata,
    input  logic                            s_axi_lite_rready,
    output logic [1:0]                      s_axi_lite_rresp,
    output logic                            s_axi_lite_rvalid,
    input  logic [`PIXGEN_DATA_W-1:0]       s_axi_lite_wdata,
    output logic                            s_axi_lite_wready,
    input  logic                            s_axi_lite_wvalid
);

    import pixgen_pkg::*;

    pixgen_ctrl_t ctrl;
    raster_pix_t  pos;
    logic         pos_valid;
    gray_pix_t    pix;
    logic         pix_valid;
    // shared stall, from the packer back to every stage
    logic         advance;

    axil_regfile regs0 (
        .out_stream_aclk    (out_stream_aclk),
        .periph_resetn      (periph_resetn),
        .s_axi_lite_awaddr  (s_axi_lite_awaddr),
        .s_axi_lite_awvalid (s_axi_lite_awvalid),
        .s_axi_lite_awready (s_axi_lite_awready),
        .s_axi_lite_wdata   (s_axi_lite_wdata),
        .s_axi_lite_wvalid  (s_axi_lite_wvalid),
        .s_axi_lite_wready  (s_axi_lite_wready),
        .s_axi_lite_bvalid  (s_axi_lite_bvalid),
        .s_axi_lite_bresp   (s_axi_lite_bresp),
        .s_axi_lite_bready  (s_axi_lite_bready),
        .s_axi_lite_araddr  (s_axi_lite_araddr),
        .s_axi_lite_arvalid (s_axi_lite_arvalid),
        .s_axi_lite_arready (s_axi_lite_arready),
        .s_axi_lite_rvalid  (s_axi_lite_rvalid),
        .s_axi_lite_rdata   (s_axi_lite_rdata),
        .s_axi_lite_rresp   (s_axi_lite_rresp),
        .s_axi_lite_rready  (s_axi_lite_rready),
        .ctrl               (ctrl)
    );

    tile_raster raster0 (
        .out_stream_aclk (out_stream_aclk),
        .periph_resetn   (periph_resetn),
        .ctrl            (ctrl),
        .advance         (advance),
        .pos             (pos),
        .pos_valid       (pos_valid)
    );

    gradient_shader shader0 (
        .out_stream_aclk (out_stream_aclk),
        .periph_resetn   (periph_resetn),
        .pos             (pos),
        .pos_valid       (pos_valid),
        .advance         (advance),
        .pix             (pix),
        .pix_valid       (pix_valid)
    );

    pixel_packer packer0 (
        .out_stream_aclk   (out_stream_aclk),
        .periph_resetn     (periph_resetn),
        .pix               (pix),
        .pix_valid         (pix_valid),
        .advance           (advance),
        .out_stream_tdata  (out_stream_tdata),
        .out_stream_tkeep  (out_stream_tkeep),
        .out_stream_tlast  (out_stream_tlast),
        .out_stream_tready (out_stream_tready),
        .out_stream_tvalid (out_stream_tvalid),
        .out_stream_tuser  (out_stream_tuser)
    );

endmodule

// File: hdl/pixel_packer.sv
`timescale 1ns/1ns
`include "pixgen_settings.svh"

module pixel_packer (
    input  logic                          out_stream_aclk,
    input  logic                          periph_resetn,
    input  pixgen_pkg::gray_pix_t         pix,
    input  logic                          pix_valid,
    output logic                          advance,
    output logic [`PIXGEN_DATA_W-1:0]     out_stream_tdata,
    output logic [`PIXGEN_DATA_W/8-1:0]   out_stream_tkeep,
    output logic                          out_stream_tlast,
    input  logic                          out_stream_tready,
    output logic                          out_stream_tvalid,
    output logic [0:0]                    out_stream_tuser
);

    // whole pipe moves when the output slot is free or being taken
    assign advance = !out_stream_tvalid || out_stream_tready;

    // every byte lane always valid
    assign out_stream_tkeep = '1;

    always_ff @(posedge out_stream_aclk) begin
        if (!periph_resetn) begin
            out_stream_tvalid <= 1'b0;
        end else if (advance) begin
            out_stream_tvalid <= pix_valid;
        end
    end

    // beat payload
    // top byte zero, gray copied to r, g and b
    always_ff @(posedge out_stream_aclk) begin
        if (advance) begin
            out_stream_tdata    <= {8'h00, pix.gray, pix.gray, pix.gray};
            // end of row
            out_stream_tlast    <= pix.eol;
            // start of frame
            out_stream_tuser[0] <= pix.sof;
        end
    end

endmodule

// File: hdl/pixgen_pkg.sv
`include "pixgen_settings.svh"

package pixgen_pkg;

    // write side tracks address and data separately
    typedef enum logic [2:0] {
        wr_idle,
        wr_wait_data,
        wr_wait_addr,
        wr_write,
        wr_resp
    } axil_wr_state_e;

    // read side has one fetch cycle before data is shown
    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,
        rd_present
    } axil_rd_state_e;

    // decode never misses, so OKAY is the only response
    typedef enum logic [1:0] {
        axil_okay = 2'b00
    } axil_resp_e;

    // controls published by the register file
    typedef struct packed {
        logic run;
    } pixgen_ctrl_t;

    // one raster position with frame markers
    typedef struct packed {
        logic [`PIXGEN_X_W-1:0] x;
        logic [`PIXGEN_Y_W-1:0] y;
        logic                   sof;
        logic                   eol;
    } raster_pix_t;

    // shaded pixel, markers travel alongside
    typedef struct packed {
        logic [7:0] gray;
        logic       sof;
        logic       eol;
    } gray_pix_t;

endpackage

// File: hdl/pixgen_settings.svh
`ifndef PIXGEN_SETTINGS_SVH
`define PIXGEN_SETTINGS_SVH

// tile geometry in pixels
`define PIXGEN_TILE_W 24
`define PIXGEN_TILE_H 24

// raster counter widths, must cover tile size
`define PIXGEN_X_W 5
`define PIXGEN_Y_W 5

// register file depth, addresses alias above this
`define PIXGEN_REG_COUNT 8

// bus widths
`define PIXGEN_AXIL_ADDR_W 8
`define PIXGEN_DATA_W 32

`endif

// File: hdl/tile_raster.sv
`timescale 1ns/1ns
`include "pixgen_settings.svh"

module tile_raster (
    input  logic                       out_stream_aclk,
    input  logic                       periph_resetn,
    input  pixgen_pkg::pixgen_ctrl_t   ctrl,
    input  logic                       advance,
    output pixgen_pkg::raster_pix_t    pos,
    output logic                       pos_valid
);

    localparam logic [`PIXGEN_X_W-1:0] x_last = `PIXGEN_X_W'(`PIXGEN_TILE_W - 1);
    localparam logic [`PIXGEN_Y_W-1:0] y_last = `PIXGEN_Y_W'(`PIXGEN_TILE_H - 1);

    logic [`PIXGEN_X_W-1:0] x;
    logic [`PIXGEN_Y_W-1:0] y;
    logic                   row_end;
    logic                   frame_end;

    assign row_end   = (x == x_last);
    assign frame_end = row_end && (y == y_last);

    // x fastest, y carries on row end
    always_ff @(posedge out_stream_aclk) begin
        if (!periph_resetn) begin
            x         <= '0;
            y         <= '0;
            pos_valid <= 1'b0;
        end else if (advance) begin
            if (pos_valid && !frame_end) begin
                // mid frame keeps going even if run drops
                if (row_end) begin
                    x <= '0;
                    y <= y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end else begin
                // frame boundary or idle, new frame only while run set
                x         <= '0;
                y         <= '0;
                pos_valid <= ctrl.run;
            end
        end
    end

    // markers come straight from the counters
    always_comb begin
        pos.x   = x;
        pos.y   = y;
        pos.sof = (x == '0) && (y == '0);
        pos.eol = row_end;
    end

endmodule

// File: tb/pixel_generator_chk.sv
`timescale 1ns/1ns
`include "pixgen_settings.svh"

module pixel_generator_chk (
    input logic                      out_stream_aclk,
    input logic                      periph_resetn,
    input logic [`PIXGEN_DATA_W-1:0] out_stream_tdata,
    input logic                      out_stream_tlast,
    input logic [0:0]                out_stream_tuser,
    input logic                      out_stream_tvalid,
    input logic                      out_stream_tready,
    input logic                      s_axi_lite_bvalid,
    input logic                      s_axi_lite_bready,
    input logic                      s_axi_lite_rvalid,
    input logic                      s_axi_lite_rready,
    input logic [`PIXGEN_DATA_W-1:0] s_axi_lite_rdata
);

    // failures seen so far, read by the testbench
    int unsigned fail_count = 0;

    // stalled beat keeps its payload
    stream_hold: assert property (@(posedge out_stream_aclk) disable iff (!periph_resetn)
        out_stream_tvalid && !out_stream_tready |=>
            out_stream_tvalid &&
            $stable({out_stream_tdata, out_stream_tlast, out_stream_tuser}))
    else begin
        fail_count++;
        $error("stream beat changed while stalled");
    end

    bvalid_hold: assert property (@(posedge out_stream_aclk) disable iff (!periph_resetn)
        s_axi_lite_bvalid && !s_axi_lite_bready |=> s_axi_lite_bvalid)
    else begin
        fail_count++;
        $error("bvalid dropped before bready");
    end

    // read data frozen until taken
    rvalid_hold: assert property (@(posedge out_stream_aclk) disable iff (!periph_resetn)
        s_axi_lite_rvalid && !s_axi_lite_rready |=>
            s_axi_lite_rvalid && $stable(s_axi_lite_rdata))
    else begin
        fail_count++;
        $error("rvalid or rdata changed before rready");
    end

    reset_quiet: assert property (@(posedge out_stream_aclk)
        !periph_resetn |=> !out_stream_tvalid)
    else begin
        fail_count++;
        $error("tvalid high after reset");
    end

endmodule

bind pixel_generator pixel_generator_chk chk0 (
    .out_stream_aclk   (out_stream_aclk),
    .periph_resetn     (periph_resetn),
    .out_stream_tdata  (out_stream_tdata),
    .out_stream_tlast  (out_stream_tlast),
    .out_stream_tuser  (out_stream_tuser),
    .out_stream_tvalid (out_stream_tvalid),
    .out_stream_tready (out_stream_tready),
    .s_axi_lite_bvalid (s_axi_lite_bvalid),
    .s_axi_lite_bready (s_axi_lite_bready),
    .s_axi_lite_rvalid (s_axi_lite_rvalid),
    .s_axi_lite_rready (s_axi_lite_rready),
    .s_axi_lite_rdata  (s_axi_lite_rdata)
);

// File: tb/pixel_generator_tb.sv
`timescale 1ns/1ns
`include "pixgen_settings.svh"

module pixel_generator_tb;

    localparam int frame_beats = `PIXGEN_TILE_W * `PIXGEN_TILE_H;
    // per-wait limits in clock cycles
    localparam int hs_limit    = 50;
    localparam int frame_limit = 4000;
    localparam int op_count    = 16;

    // one register access
    // order 0 together, 1 address first, 2 data first
    typedef struct packed {
        logic                           wr;
        logic [`PIXGEN_AXIL_ADDR_W-1:0] addr;
        logic [`PIXGEN_DATA_W-1:0]      data;
        logic [1:0]                     order;
        logic [`PIXGEN_DATA_W-1:0]      rd_exp;
    } reg_op_t;

    // reads expect the word at index addr[4:2]
    localparam reg_op_t op_table [op_count] = '{
        {1'b0, 8'h04, 32'h0000_0000, 2'd0, 32'h0000_0000},
        {1'b1, 8'h04, 32'ha5a5_0001, 2'd0, 32'h0000_0000},
        {1'b1, 8'h08, 32'h1234_5678, 2'd1, 32'h0000_0000},
        {1'b1, 8'h0c, 32'hdead_beef, 2'd2, 32'h0000_0000},
        {1'b1, 8'h1c, 32'h0bad_f00d, 2'd1, 32'h0000_0000},
        {1'b0, 8'h04, 32'h0000_0000, 2'd0, 32'ha5a5_0001},
        {1'b0, 8'h08, 32'h0000_0000, 2'd0, 32'h1234_5678},
        {1'b0, 8'h0c, 32'h0000_0000, 2'd0, 32'hdead_beef},
        {1'b0, 8'h1c, 32'h0000_0000, 2'd0, 32'h0bad_f00d},
        // 0x28 lands on word 2
        {1'b1, 8'h28, 32'hcafe_0002, 2'd2, 32'h0000_0000},
        {1'b0, 8'h08, 32'h0000_0000, 2'd0, 32'hcafe_0002},
        {1'b0, 8'h3c, 32'h0000_0000, 2'd0, 32'h0bad_f00d},
        {1'b1, 8'h30, 32'h5555_aaaa, 2'd0, 32'h0000_0000},
        {1'b0, 8'h10, 32'h0000_0000, 2'd0, 32'h5555_aaaa},
        // word 0 through alias, run bit stays clear
        {1'b1, 8'h20, 32'h0000_0010, 2'd1, 32'h0000_0000},
        {1'b0, 8'h00, 32'h0000_0000, 2'd0, 32'h0000_0010}
    };

    // fp16 gradient per row, 1.0 on top down to 0.0
    localparam logic [15:0] half_table [`PIXGEN_TILE_H] = '{
        16'h3c00, 16'h3bdc, 16'h3bb8, 16'h3b94, 16'h3b70, 16'h3b4c,
        16'h3b28, 16'h3b04, 16'h3ae0, 16'h3abc, 16'h3a98, 16'h3a74,
        16'h3a50, 16'h3a2c, 16'h3a08, 16'h39e4, 16'h39c0, 16'h399c,
        16'h3978, 16'h3954, 16'h3930, 16'h390c, 16'h38e8, 16'h0000
    };

    logic                           out_stream_aclk;
    logic                           periph_resetn;
    logic [`PIXGEN_DATA_W-1:0]      out_stream_tdata;
    logic [`PIXGEN_DATA_W/8-1:0]    out_stream_tkeep;
    logic                           out_stream_tlast;
    logic                           out_stream_tready;
    logic                           out_stream_tvalid;
    logic [0:0]                     out_stream_tuser;
    logic [`PIXGEN_AXIL_ADDR_W-1:0] s_axi_lite_araddr;
    logic                           s_axi_lite_arready;
    logic                           s_axi_lite_arvalid;
    logic [`PIXGEN_AXIL_ADDR_W-1:0] s_axi_lite_awaddr;
    logic                           s_axi_lite_awready;
    logic                           s_axi_lite_awvalid;
    logic                           s_axi_lite_bready;
    logic [1:0]                     s_axi_lite_bresp;
    logic                           s_axi_lite_bvalid;
    logic [`PIXGEN_DATA_W-1:0]      s_axi_lite_rdata;
    logic                           s_axi_lite_rready;
    logic [1:0]                     s_axi_lite_rresp;
    logic                           s_axi_lite_rvalid;
    logic [`PIXGEN_DATA_W-1:0]      s_axi_lite_wdata;
    logic                           s_axi_lite_wready;
    logic                           s_axi_lite_wvalid;

    logic [7:0] row_gray [`PIXGEN_TILE_H];
    logic       random_ready = 1'b0;
    integer     seed         = 32'h383fbea0;
    // beat position inside the current frame
    int         beat_k       = 0;
    int         total_beats  = 0;
    int         frames_done  = 0;
    int         errors       = 0;
    int         timeouts     = 0;

    pixel_generator dut0 (.*);

    initial begin
        out_stream_aclk = 1'b0;
        forever #2 out_stream_aclk = ~out_stream_aclk;
    end

    // value * 255 truncated, done in real arithmetic
    function automatic logic [7:0] gray_from_half(input logic [15:0] h);
        real v;
        int  e;
        v = 1.0 + real'(h[9:0]) / 1024.0;
        e = int'(h[14:10]);
        if (h[15] || e == 0) begin
            v = 0.0;
        end
        while (e < 15) begin
            v = v / 2.0;
            e = e + 1;
        end
        while (e > 15) begin
            v = v * 2.0;
            e = e - 1;
        end
        v = v * 255.0;
        if (v >= 255.0) begin
            gray_from_half = 8'hff;
        end else begin
            gray_from_half = 8'($rtoi(v));
        end
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic end_run();
        int asserts;
        asserts = int'(dut0.chk0.fail_count);
        $display("check errors %0d, timeouts %0d, assertion failures %0d",
                 errors, timeouts, asserts);
        if (errors == 0 && timeouts == 0 && asserts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic time_out(input string what);
        timeouts++;
        $display("timed out at %0t ns while waiting for %s", $time, what);
        end_run();
    endtask

    // expected beat from the raster position, x fastest
    task automatic check_beat();
        int          x;
        int          y;
        logic [31:0] want;
        x    = beat_k % `PIXGEN_TILE_W;
        y    = beat_k / `PIXGEN_TILE_W;
        want = {8'h00, row_gray[y], row_gray[y], row_gray[y]};
        compare_value($sformatf("tdata beat %0d", beat_k), out_stream_tdata, want);
        compare_value($sformatf("tkeep beat %0d", beat_k), 32'(out_stream_tkeep), 32'hf);
        compare_value($sformatf("tlast beat %0d", beat_k), 32'(out_stream_tlast),
                      32'(x == `PIXGEN_TILE_W - 1));
        compare_value($sformatf("tuser beat %0d", beat_k), 32'(out_stream_tuser),
                      32'(beat_k == 0));
        total_beats++;
        beat_k++;
        if (beat_k == frame_beats) begin
            beat_k = 0;
            frames_done++;
        end
    endtask

    // tready and the scoreboard share one process
    // a beat counts when valid and ready meet before the next rising edge
    initial begin
        out_stream_tready = 1'b0;
        forever begin
            @(negedge out_stream_aclk);
            if (random_ready) begin
                out_stream_tready = ($random(seed) & 3) != 0;
            end else begin
                out_stream_tready = periph_resetn;
            end
            if (periph_resetn && out_stream_tvalid && out_stream_tready) begin
                check_beat();
            end
        end
    end

    // hold until every raised valid has its ready, then drop them
    task automatic wait_write_accept();
        int n;
        n = 0;
        while (((s_axi_lite_awvalid && !s_axi_lite_awready) ||
                (s_axi_lite_wvalid && !s_axi_lite_wready)) && n < hs_limit) begin
            @(negedge out_stream_aclk);
            n++;
        end
        if (n >= hs_limit) begin
            time_out("awready or wready");
        end
        @(negedge out_stream_aclk);
        s_axi_lite_awvalid = 1'b0;
        s_axi_lite_wvalid  = 1'b0;
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] order);
        int n;
        s_axi_lite_awaddr = addr;
        s_axi_lite_wdata  = data;
        s_axi_lite_awvalid = (order != 2'd2);
        s_axi_lite_wvalid  = (order != 2'd1);
        wait_write_accept();
        // second half of a split write
        s_axi_lite_awvalid = (order == 2'd2);
        s_axi_lite_wvalid  = (order == 2'd1);
        wait_write_accept();
        n = 0;
        while (!s_axi_lite_bvalid && n < hs_limit) begin
            @(negedge out_stream_aclk);
            n++;
        end
        if (!s_axi_lite_bvalid) begin
            time_out("bvalid");
        end
        // host stalls the response, bvalid must stay up
        repeat (2) @(negedge out_stream_aclk);
        compare_value($sformatf("bvalid held addr %h", addr), 32'(s_axi_lite_bvalid), 32'h1);
        // OKAY expected
        compare_value($sformatf("bresp addr %h", addr), 32'(s_axi_lite_bresp), 32'h0);
        s_axi_lite_bready = 1'b1;
        @(negedge out_stream_aclk);
        s_axi_lite_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, input logic [31:0] want);
        int n;
        s_axi_lite_araddr  = addr;
        s_axi_lite_arvalid = 1'b1;
        n = 0;
        while (!s_axi_lite_arready && n < hs_limit) begin
            @(negedge out_stream_aclk);
            n++;
        end
        if (!s_axi_lite_arready) begin
            time_out("arready");
        end
        @(negedge out_stream_aclk);
        s_axi_lite_arvalid = 1'b0;
        n = 0;
        while (!s_axi_lite_rvalid && n < hs_limit) begin
            @(negedge out_stream_aclk);
            n++;
        end
        if (!s_axi_lite_rvalid) begin
            time_out("rvalid");
        end
        // rready held back, data must stay put
        repeat (2) @(negedge out_stream_aclk);
        compare_value($sformatf("rvalid held addr %h", addr), 32'(s_axi_lite_rvalid), 32'h1);
        compare_value($sformatf("rdata addr %h", addr), s_axi_lite_rdata, want);
        compare_value($sformatf("rresp addr %h", addr), 32'(s_axi_lite_rresp), 32'h0);
        s_axi_lite_rready = 1'b1;
        @(negedge out_stream_aclk);
        s_axi_lite_rready = 1'b0;
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (frames_done < target && n < frame_limit * 2) begin
            @(negedge out_stream_aclk);
            n++;
        end
        if (frames_done < target) begin
            time_out($sformatf("end of frame %0d", target));
        end
    endtask

    task automatic wait_beat(input int k);
        int n;
        n = 0;
        while (beat_k < k && n < frame_limit) begin
            @(negedge out_stream_aclk);
            n++;
        end
        if (beat_k < k) begin
            time_out($sformatf("beat %0d", k));
        end
    endtask

    // quiet period, running out the limit is the good outcome
    task automatic expect_quiet(input int cycles);
        int n;
        int start;
        n     = 0;
        start = total_beats;
        while (total_beats == start && n < cycles) begin
            @(negedge out_stream_aclk);
            n++;
        end
        compare_value("beats while stopped", total_beats, start);
    endtask

    initial begin
        periph_resetn      = 1'b0;
        s_axi_lite_araddr  = '0;
        s_axi_lite_arvalid = 1'b0;
        s_axi_lite_awaddr  = '0;
        s_axi_lite_awvalid = 1'b0;
        s_axi_lite_bready  = 1'b0;
        s_axi_lite_rready  = 1'b0;
        s_axi_lite_wdata   = '0;
        s_axi_lite_wvalid  = 1'b0;
        for (int i = 0; i < `PIXGEN_TILE_H; i++) begin
            row_gray[i] = gray_from_half(half_table[i]);
        end
        repeat (2) @(posedge out_stream_aclk);
        @(negedge out_stream_aclk);
        periph_resetn = 1'b1;

        // idle outputs straight after reset
        compare_value("tvalid after reset", 32'(out_stream_tvalid), 32'h0);
        compare_value("bvalid after reset", 32'(s_axi_lite_bvalid), 32'h0);
        compare_value("rvalid after reset", 32'(s_axi_lite_rvalid), 32'h0);
        compare_value("arready after reset", 32'(s_axi_lite_arready), 32'h1);
        compare_value("awready after reset", 32'(s_axi_lite_awready), 32'h1);
        compare_value("wready after reset", 32'(s_axi_lite_wready), 32'h1);
        expect_quiet(100);

        for (int i = 0; i < op_count; i++) begin
            if (op_table[i].wr) begin
                axil_write(op_table[i].addr, op_table[i].data, op_table[i].order);
            end else begin
                axil_read(op_table[i].addr, op_table[i].rd_exp);
            end
        end
        compare_value("beats with run clear", total_beats, 0);

        // run with tready held high
        axil_write(8'h00, 32'h0000_0001, 2'd0);
        wait_frames(2);
        // same sequence under random back-pressure
        random_ready = 1'b1;
        wait_frames(4);

        // drop run mid-frame, frame must still finish
        wait_beat(200);
        axil_write(8'h00, 32'h0000_0000, 2'd2);
        wait_frames(5);
        expect_quiet(400);
        compare_value("frames after stop", frames_done, 5);
        compare_value("beat index after stop", beat_k, 0);
        compare_value("total beats", total_beats, 5 * frame_beats);

        end_run();
    end

endmodule
